/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_nn_trainer
FILELIST  ?= nn_trainer.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0 -Wno-fatal
PASS_MSG  ?= sim passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard source/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* nn_trainer.f */
+incdir+source
source/nn_pkg.sv
source/weight_store.sv
source/forward_layer.sv
source/error_calculator.sv
source/weight_updater.sv
source/nn_trainer_top.sv
tests/tb_nn_trainer.sv

/* source/error_calculator.sv */
`timescale 1ns/1ps
`default_nettype none

`include "nn_defines.svh"

module error_calculator
    import nn_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   fwd_valid,
    input  fwd_t                   fwd,
    input  logic                   fwd_learn,
    output logic                   result_valid,
    output result_t                result,
    output logic                   result_learn,
    output logic [`NN_COUNT_W-1:0] correct_count
);

    err_vec_t               err;
    vec_t                   delta;
    logic [`NN_CLASS_W-1:0] pred_class;
    logic [`NN_CLASS_W-1:0] target_class;

    // Largest element, strict compare keeps the lowest index on ties
    function automatic logic [`NN_CLASS_W-1:0] argmax(input vec_t v);
        logic [`NN_CLASS_W-1:0] best;
        best = '0;
        for (int k = 1; k < `NN_NEURONS; k++) begin
            if (v[k] > v[best]) begin
                best = k[`NN_CLASS_W-1:0];
            end
        end
        return best;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Errors and deltas
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < `NN_NEURONS; i++) begin
            err[i]   = fwd.y[i] - fwd.act[i];
            // Derivative of the linear activation is one
            delta[i] = sat_data(err[i]);
        end
    end

    assign pred_class   = argmax(fwd.act);
    assign target_class = argmax(fwd.y);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid  <= 1'b0;
            result_learn  <= 1'b0;
            correct_count <= '0;
        end else begin
            result_valid <= fwd_valid;
            if (fwd_valid) begin
                result_learn <= fwd_learn;
                if (pred_class == target_class) begin
                    correct_count <= correct_count + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fwd_valid) begin
            result.x            <= fwd.x;
            result.act          <= fwd.act;
            result.err          <= err;
            result.delta        <= delta;
            result.pred_class   <= pred_class;
            result.target_class <= target_class;
        end
    end

endmodule

`default_nettype wire

/* source/forward_layer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "nn_defines.svh"

module forward_layer
    import nn_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        sample_valid,
    input  sample_t     sample,
    input  logic        learn,
    input  weight_mat_t weights,
    output logic        fwd_valid,
    output fwd_t        fwd,
    output logic        fwd_learn
);

    // Four floored products of 32 bits need two extra bits of headroom
    localparam int PROD_W = 2 * `NN_DATA_W;
    localparam int ACC_W  = PROD_W + $clog2(`NN_NEURONS);

    logic signed [ACC_W-1:0] acc [`NN_NEURONS];
    vec_t                    act;

    ////////////////////////////////////////////////////////////////////////////
    // Matrix-vector product
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        logic signed [PROD_W-1:0] prod;
        for (int i = 0; i < `NN_NEURONS; i++) begin
            acc[i] = '0;
            for (int j = 0; j < `NN_NEURONS; j++) begin
                prod   = weights[i][j] * sample.x[j];
                acc[i] = acc[i] + (prod >>> `NN_FRAC);
            end
            // Linear activation
            act[i] = sat_data(acc[i]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fwd_valid <= 1'b0;
            fwd_learn <= 1'b0;
        end else begin
            fwd_valid <= sample_valid;
            if (sample_valid) begin
                fwd_learn <= learn;
            end
        end
    end

    // Inputs and targets ride along with the activations
    always_ff @(posedge clk) begin
        if (sample_valid) begin
            fwd.x   <= sample.x;
            fwd.y   <= sample.y;
            fwd.act <= act;
        end
    end

endmodule

`default_nettype wire

/* source/nn_defines.svh */
`ifndef NN_DEFINES_SVH
`define NN_DEFINES_SVH

// Layer geometry
`define NN_NEURONS      4
`define NN_CLASS_W      2

// Fixed-point format, Q7.8
`define NN_DATA_W       16
`define NN_FRAC         8

// Training
`define NN_LR_SHIFT     4
`define NN_WEIGHT_RESET 32
`define NN_COUNT_W      16

`endif

/* source/nn_pkg.sv */
`default_nettype none

`include "nn_defines.svh"

package nn_pkg;

    typedef logic signed [`NN_DATA_W-1:0] data_t;
    typedef logic signed [`NN_DATA_W:0]   err_t;

    typedef data_t [`NN_NEURONS-1:0] vec_t;
    typedef err_t  [`NN_NEURONS-1:0] err_vec_t;

    // Row i feeds output neuron i, column j is input j
    typedef vec_t  [`NN_NEURONS-1:0] weight_mat_t;

    typedef struct packed {
        vec_t x;
        vec_t y;
    } sample_t;

    typedef struct packed {
        vec_t x;
        vec_t y;
        vec_t act;
    } fwd_t;

    typedef struct packed {
        vec_t                    x;
        vec_t                    act;
        err_vec_t                err;
        vec_t                    delta;
        logic [`NN_CLASS_W-1:0]  pred_class;
        logic [`NN_CLASS_W-1:0]  target_class;
    } result_t;

    // Wide enough for any sum or product handed to the saturator
    localparam int SAT_IN_W = 2 * `NN_DATA_W + 8;

    localparam logic signed [SAT_IN_W-1:0] DATA_MAX = (1 <<< (`NN_DATA_W - 1)) - 1;
    localparam logic signed [SAT_IN_W-1:0] DATA_MIN = -(1 <<< (`NN_DATA_W - 1));

    // Clamp a wide signed value to the data range
    function automatic data_t sat_data(input logic signed [SAT_IN_W-1:0] v);
        if (v > DATA_MAX) begin
            return data_t'(DATA_MAX);
        end else if (v < DATA_MIN) begin
            return data_t'(DATA_MIN);
        end
        return data_t'(v);
    endfunction

endpackage

`default_nettype wire

/* source/nn_trainer_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "nn_defines.svh"

module nn_trainer_top
    import nn_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   sample_valid,
    input  sample_t                sample,
    input  logic                   learn,
    output logic                   result_valid,
    output result_t                result,
    output logic [`NN_COUNT_W-1:0] correct_count,
    output logic                   weights_valid,
    output weight_mat_t            weights
);

    logic        fwd_valid;
    fwd_t        fwd;
    logic        fwd_learn;
    logic        result_learn;
    logic        write_en;
    weight_mat_t new_weights;

    // Only learning samples touch the matrix
    assign write_en = result_valid & result_learn;

    weight_store u_weight_store (
        .clk           (clk),
        .rst_n         (rst_n),
        .write_en      (write_en),
        .new_weights   (new_weights),
        .weights       (weights),
        .weights_valid (weights_valid)
    );

    forward_layer u_forward_layer (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .sample       (sample),
        .learn        (learn),
        .weights      (weights),
        .fwd_valid    (fwd_valid),
        .fwd          (fwd),
        .fwd_learn    (fwd_learn)
    );

    error_calculator u_error_calculator (
        .clk           (clk),
        .rst_n         (rst_n),
        .fwd_valid     (fwd_valid),
        .fwd           (fwd),
        .fwd_learn     (fwd_learn),
        .result_valid  (result_valid),
        .result        (result),
        .result_learn  (result_learn),
        .correct_count (correct_count)
    );

    weight_updater u_weight_updater (
        .result      (result),
        .weights     (weights),
        .new_weights (new_weights)
    );

endmodule

`default_nettype wire

/* source/weight_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "nn_defines.svh"

module weight_store
    import nn_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        write_en,
    input  weight_mat_t new_weights,
    output weight_mat_t weights,
    output logic        weights_valid
);

    ////////////////////////////////////////////////////////////////////////////
    // Weight matrix, loaded whole on every learning step
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NN_NEURONS; i++) begin
                for (int j = 0; j < `NN_NEURONS; j++) begin
                    weights[i][j] <= data_t'(`NN_WEIGHT_RESET);
                end
            end
        end else if (write_en) begin
            weights <= new_weights;
        end
    end

    // New matrix visible one cycle after the write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weights_valid <= 1'b0;
        end else begin
            weights_valid <= write_en;
        end
    end

endmodule

`default_nettype wire

/* source/weight_updater.sv */
`timescale 1ns/1ps
`default_nettype none

`include "nn_defines.svh"

module weight_updater
    import nn_pkg::*;
(
    input  result_t     result,
    input  weight_mat_t weights,
    output weight_mat_t new_weights
);

    localparam int PROD_W = 2 * `NN_DATA_W;

    // Fraction realignment and learning rate in one floor shift
    localparam int UPD_SHIFT = `NN_FRAC + `NN_LR_SHIFT;

    ////////////////////////////////////////////////////////////////////////////
    // Delta rule, w[i][j] += (delta[i] * x[j]) >> (frac + lr)
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        logic signed [PROD_W-1:0] prod;
        logic signed [PROD_W-1:0] upd;
        for (int i = 0; i < `NN_NEURONS; i++) begin
            for (int j = 0; j < `NN_NEURONS; j++) begin
                prod              = result.delta[i] * result.x[j];
                upd               = prod >>> UPD_SHIFT;
                new_weights[i][j] = sat_data(weights[i][j] + upd);
            end
        end
    end

endmodule

`default_nettype wire

/* tests/tb_nn_trainer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "nn_defines.svh"

module tb_nn_trainer
    import nn_pkg::*;
();

    localparam int    N_SAMPLES = 38;
    localparam int    TIMEOUT   = 20 * N_SAMPLES + 50;
    localparam data_t D_MAX     = data_t'((1 << (`NN_DATA_W - 1)) - 1);
    localparam data_t D_MIN     = data_t'(1 << (`NN_DATA_W - 1));

    logic                   clk;
    logic                   rst_n;
    logic                   sample_valid;
    sample_t                sample;
    logic                   learn;
    logic                   result_valid;
    result_t                result;
    logic [`NN_COUNT_W-1:0] correct_count;
    logic                   weights_valid;
    weight_mat_t            weights;

    weight_mat_t            model_w;
    logic [`NN_COUNT_W-1:0] model_count;
    result_t                exp_results [$];
    logic [`NN_COUNT_W-1:0] exp_counts [$];
    weight_mat_t            exp_weights [$];
    string                  cur_test;
    int                     value_errors;
    int                     protocol_errors;
    int                     cycles;
    int                     last_mag;

    nn_trainer_top u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_valid  (sample_valid),
        .sample        (sample),
        .learn         (learn),
        .result_valid  (result_valid),
        .result        (result),
        .correct_count (correct_count),
        .weights_valid (weights_valid),
        .weights       (weights)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("Timeout after %0d cycles, expected valid pulses never arrived", cycles);
            $display("sim failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic data_t clamp_data(input longint v);
        if (v > longint'(D_MAX)) begin
            return D_MAX;
        end
        if (v < longint'(D_MIN)) begin
            return D_MIN;
        end
        return data_t'(v);
    endfunction

    // First maximum wins
    function automatic logic [`NN_CLASS_W-1:0] top_index(input vec_t v);
        int best;
        best = 0;
        for (int k = 1; k < `NN_NEURONS; k++) begin
            if ($signed(v[k]) > $signed(v[best])) begin
                best = k;
            end
        end
        return best[`NN_CLASS_W-1:0];
    endfunction

    function automatic result_t model_step(input sample_t s, input weight_mat_t w,
                                           output weight_mat_t w_next);
        result_t r;
        longint  acc;
        longint  upd;
        r.x = s.x;
        for (int i = 0; i < `NN_NEURONS; i++) begin
            acc = 0;
            for (int j = 0; j < `NN_NEURONS; j++) begin
                acc += (longint'($signed(w[i][j])) * longint'($signed(s.x[j]))) >>> `NN_FRAC;
            end
            r.act[i] = clamp_data(acc);
        end
        for (int i = 0; i < `NN_NEURONS; i++) begin
            acc        = longint'($signed(s.y[i])) - longint'($signed(r.act[i]));
            r.err[i]   = err_t'(acc);
            r.delta[i] = clamp_data(acc);
        end
        r.pred_class   = top_index(r.act);
        r.target_class = top_index(s.y);
        for (int i = 0; i < `NN_NEURONS; i++) begin
            for (int j = 0; j < `NN_NEURONS; j++) begin
                upd = (longint'($signed(r.delta[i])) * longint'($signed(s.x[j])))
                      >>> (`NN_FRAC + `NN_LR_SHIFT);
                w_next[i][j] = clamp_data(longint'($signed(w[i][j])) + upd);
            end
        end
        return r;
    endfunction

    function automatic vec_t make_vec(input int v0, input int v1, input int v2, input int v3);
        vec_t v;
        v[0] = data_t'(v0);
        v[1] = data_t'(v1);
        v[2] = data_t'(v2);
        v[3] = data_t'(v3);
        return v;
    endfunction

    function automatic sample_t rand_sample(input int span);
        sample_t s;
        for (int i = 0; i < `NN_NEURONS; i++) begin
            s.x[i] = data_t'(int'($urandom_range(2 * span)) - span);
            s.y[i] = data_t'(int'($urandom_range(2 * span)) - span);
        end
        return s;
    endfunction

    function automatic data_t extreme_val();
        case ($urandom_range(2))
            0: return D_MAX;
            1: return D_MIN;
            default: return '0;
        endcase
    endfunction

    function automatic sample_t extreme_sample();
        sample_t s;
        for (int i = 0; i < `NN_NEURONS; i++) begin
            s.x[i] = extreme_val();
            s.y[i] = extreme_val();
        end
        return s;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Checks and stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_result(input string name, input result_t exp_v, input result_t act_v);
        if (act_v !== exp_v) begin
            $display("FAILED %s: result expected %h actual %h", name, exp_v, act_v);
            value_errors++;
        end
    endtask

    task automatic check_weights(input string name, input weight_mat_t exp_v,
                                 input weight_mat_t act_v);
        if (act_v !== exp_v) begin
            $display("FAILED %s: weights expected %h actual %h", name, exp_v, act_v);
            value_errors++;
        end
    endtask

    task automatic check_count(input string name, input logic [`NN_COUNT_W-1:0] exp_v,
                               input logic [`NN_COUNT_W-1:0] act_v);
        if (act_v !== exp_v) begin
            $display("FAILED %s: correct_count expected %0d actual %0d", name, exp_v, act_v);
            value_errors++;
        end
    endtask

    task automatic reset_dut();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < `NN_NEURONS; i++) begin
            for (int j = 0; j < `NN_NEURONS; j++) begin
                model_w[i][j] = data_t'(`NN_WEIGHT_RESET);
            end
        end
        model_count = '0;
    endtask

    // Strobe one sample, the next strobe follows four cycles later
    task automatic send_sample(input sample_t s, input logic lrn);
        result_t     r;
        weight_mat_t w_next;
        r = model_step(s, model_w, w_next);
        if (r.pred_class == r.target_class) begin
            model_count = model_count + 1'b1;
        end
        exp_results.push_back(r);
        exp_counts.push_back(model_count);
        if (lrn) begin
            model_w = w_next;
            exp_weights.push_back(w_next);
        end
        @(posedge clk);
        sample_valid <= 1'b1;
        sample       <= s;
        learn        <= lrn;
        @(posedge clk);
        sample_valid <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    // Wait until every expected pulse has been compared
    task automatic wait_for_drain();
        while (exp_results.size() != 0 || exp_weights.size() != 0) begin
            @(posedge clk);
        end
    endtask

    always @(negedge clk) begin : compare_outputs
        int e;
        int mag;
        if (rst_n && result_valid) begin
            if (exp_results.size() == 0) begin
                $display("Unexpected result_valid pulse during %s", cur_test);
                protocol_errors++;
            end else begin
                check_result(cur_test, exp_results.pop_front(), result);
                check_count(cur_test, exp_counts.pop_front(), correct_count);
                // Repeated training must not move away from the target
                if (cur_test == "train_fixed") begin
                    mag = 0;
                    for (int i = 0; i < `NN_NEURONS; i++) begin
                        e = int'($signed(result.err[i]));
                        mag += (e < 0) ? -e : e;
                    end
                    if (mag > last_mag) begin
                        $display("Error magnitude grew from %0d to %0d", last_mag, mag);
                        protocol_errors++;
                    end
                    last_mag = mag;
                end
            end
        end
        if (rst_n && weights_valid) begin
            if (exp_weights.size() == 0) begin
                $display("Unexpected weights_valid pulse during %s", cur_test);
                protocol_errors++;
            end else begin
                check_weights(cur_test, exp_weights.pop_front(), weights);
            end
        end
    end

    initial begin
        vec_t unit_x;
        void'($urandom(87));
        rst_n        <= 1'b0;
        sample_valid <= 1'b0;
        sample       <= '0;
        learn        <= 1'b0;
        cur_test = "reset";
        reset_dut();
        repeat (2) @(negedge clk);
        if (result_valid || weights_valid) begin
            $display("A valid output is high right after reset");
            protocol_errors++;
        end
        check_count(cur_test, '0, correct_count);
        check_weights(cur_test, model_w, weights);
        send_sample(rand_sample(256), 1'b1);
        wait_for_drain();

        cur_test = "random_learn";
        repeat (12) send_sample(rand_sample(512), 1'b1);
        wait_for_drain();

        cur_test = "no_learn";
        repeat (5) send_sample(rand_sample(512), 1'b0);
        check_weights(cur_test, model_w, weights);
        wait_for_drain();

        cur_test = "extremes";
        repeat (6) send_sample(extreme_sample(), 1'b1);
        wait_for_drain();

        // Equal reset weights give equal outputs, so pred_class is 0
        cur_test = "argmax";
        reset_dut();
        unit_x = make_vec(256, 256, 256, 256);
        send_sample(sample_t'{x: unit_x, y: make_vec(10, 10, 10, 10)}, 1'b0);
        send_sample(sample_t'{x: unit_x, y: make_vec(5, 3, 9, 1)}, 1'b0);
        send_sample(sample_t'{x: unit_x, y: make_vec(0, 7, 2, 7)}, 1'b0);
        send_sample(sample_t'{x: unit_x, y: make_vec(-5, -3, -3, -9)}, 1'b0);
        send_sample(sample_t'{x: unit_x, y: make_vec(-1, -1, -1, 0)}, 1'b0);
        send_sample(sample_t'{x: unit_x, y: make_vec(20, 20, 19, 20)}, 1'b0);
        wait_for_drain();

        cur_test = "train_fixed";
        last_mag = 32'h7fff_ffff;
        repeat (8) send_sample(sample_t'{x: unit_x, y: make_vec(512, 300, 200, 1000)}, 1'b1);

        wait_for_drain();
        repeat (5) @(posedge clk);
        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
